// ==== hdl/dcachePkg.sv ====
package dcachePkg;

  // cache geometry
  localparam int AddrW        = 32;
  localparam int WordW        = 32;
  localparam int WordsPerLine = 4;
  localparam int Sets         = 16;
  localparam int Ways         = 2;
  // byte offset inside one line
  localparam int OffsetW      = 4;
  localparam int IndexW       = 4;
  localparam int TagW         = AddrW - IndexW - OffsetW;

  // address and data
  typedef logic [AddrW-1:0]   addrT;
  typedef logic [WordW-1:0]   wordT;
  typedef logic [WordW/8-1:0] strbT;

  // one full line, word 0 in the low bits
  typedef logic [WordsPerLine*WordW-1:0] lineT;

  // address fields
  typedef logic [TagW-1:0]   tagT;
  typedef logic [IndexW-1:0] indexT;

  // word position inside a line, also the refill beat number
  typedef logic [$clog2(WordsPerLine)-1:0] beatT;

  // request controller states
  typedef enum logic [2:0] {
    idle,
    compare,
    writeBack,
    refill,
    install
  } cacheStateE;

endpackage

// ==== hdl/cacheIfs.sv ====
// controller to tag/data arrays
interface arrayIf;
  dcachePkg::indexT           rdIndex;
  logic                       installWr;
  logic                       storeWr;
  logic                       hitWay;
  dcachePkg::tagT             installTag;
  dcachePkg::lineT            storeData;
  dcachePkg::lineT            storeMask;
  dcachePkg::lineT            refillLine;
  // lookup results for last cycle's index
  dcachePkg::tagT             rdTag [dcachePkg::Ways];
  logic [dcachePkg::Ways-1:0] rdValid;
  dcachePkg::lineT            rdLine [dcachePkg::Ways];
  logic                       victimWay;
  logic                       victimDirty;

  modport ctrl (output rdIndex, installWr, storeWr, hitWay, installTag,
                output storeData, storeMask, refillLine,
                input  rdTag, rdValid, rdLine, victimWay, victimDirty);
  modport store (input  rdIndex, installWr, storeWr, hitWay, installTag,
                 input  storeData, storeMask, refillLine,
                 output rdTag, rdValid, rdLine, victimWay, victimDirty);
endinterface

// controller to memory-side line engine
interface lineIf;
  logic            fillStart;
  dcachePkg::addrT fillAddr;
  logic            fillDone;
  dcachePkg::lineT fillLine;
  logic            wbStart;
  dcachePkg::addrT wbAddr;
  dcachePkg::lineT wbLine;
  logic            wbDone;

  modport ctrl (output fillStart, fillAddr, wbStart, wbAddr, wbLine,
                input  fillDone, fillLine, wbDone);
  modport mem (input  fillStart, fillAddr, wbStart, wbAddr, wbLine,
               output fillDone, fillLine, wbDone);
endinterface

// ==== hdl/cacheArrays.sv ====
module cacheArrays (
  input  logic  clk,
  input  logic  rst_n,
  arrayIf.store arr
);

  dcachePkg::tagT  tagMem  [dcachePkg::Ways][dcachePkg::Sets];
  dcachePkg::lineT dataMem [dcachePkg::Ways][dcachePkg::Sets];

  logic [dcachePkg::Ways-1:0][dcachePkg::Sets-1:0] validQ;
  logic [dcachePkg::Ways-1:0][dcachePkg::Sets-1:0] dirtyQ;
  // one replacement bit per set
  logic [dcachePkg::Sets-1:0]                      victimQ;
  dcachePkg::indexT                                idxQ;
  logic                                            victimWay;
  dcachePkg::lineT                                 mergedLine;

  // registered index, arrays read through it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idxQ <= '0;
    end else begin
      idxQ <= arr.rdIndex;
    end
  end

  always_comb begin
    for (int w = 0; w < dcachePkg::Ways; w++) begin
      arr.rdTag[w]   = tagMem[w][idxQ];
      arr.rdValid[w] = validQ[w][idxQ];
      arr.rdLine[w]  = dataMem[w][idxQ];
    end
  end

  // an empty way first, else the set's victim bit
  always_comb begin
    if (!validQ[0][idxQ]) begin
      victimWay = 1'b0;
    end else if (!validQ[1][idxQ]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = victimQ[idxQ];
    end
  end
  assign arr.victimWay   = victimWay;
  assign arr.victimDirty = validQ[victimWay][idxQ] && dirtyQ[victimWay][idxQ];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ  <= '0;
      dirtyQ  <= '0;
      victimQ <= '0;
    end else if (arr.installWr) begin
      validQ[victimWay][idxQ] <= 1'b1;
      dirtyQ[victimWay][idxQ] <= |arr.storeMask;
      victimQ[idxQ]           <= ~victimQ[idxQ];
    end else if (arr.storeWr) begin
      dirtyQ[arr.hitWay][idxQ] <= 1'b1;
    end
  end

  // byte merge of a store hit
  assign mergedLine = (dataMem[arr.hitWay][idxQ] & ~arr.storeMask) |
                      (arr.storeData & arr.storeMask);

  always_ff @(posedge clk) begin
    if (arr.installWr) begin
      tagMem[victimWay][idxQ]  <= arr.installTag;
      dataMem[victimWay][idxQ] <= arr.refillLine;
    end else if (arr.storeWr) begin
      dataMem[arr.hitWay][idxQ] <= mergedLine;
    end
  end

endmodule

// ==== hdl/lineTransfer.sv ====
module lineTransfer (
  input  logic            clk,
  input  logic            rst_n,
  lineIf.mem              xfer,
  output logic            memRdValid_o,
  input  logic            memRdReady_i,
  output dcachePkg::addrT memRdAddr_o,
  input  dcachePkg::wordT memRdData_i,
  input  logic            memRdDataValid_i,
  input  logic            memRdLast_i,
  output logic            memWrValid_o,
  input  logic            memWrReady_i,
  output dcachePkg::addrT memWrAddr_o,
  output dcachePkg::lineT memWrData_o
);

  logic            rdPending;
  logic            receiving;
  logic            fillDoneQ;
  logic            wbPending;
  dcachePkg::beatT beat;
  dcachePkg::addrT rdAddrQ;
  dcachePkg::addrT wrAddrQ;
  dcachePkg::lineT fillBuf;
  dcachePkg::lineT wrLineQ;
  logic            beatTaken;

  assign beatTaken = receiving && memRdDataValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdPending <= 1'b0;
      receiving <= 1'b0;
      fillDoneQ <= 1'b0;
      wbPending <= 1'b0;
      beat      <= '0;
    end else begin
      // read request held until memory takes it
      if (xfer.fillStart) begin
        rdPending <= 1'b1;
        beat      <= '0;
      end else if (rdPending && memRdReady_i) begin
        rdPending <= 1'b0;
        receiving <= 1'b1;
      end
      if (beatTaken) begin
        beat <= beat + 1'b1;
        if (memRdLast_i) begin
          receiving <= 1'b0;
        end
      end
      fillDoneQ <= beatTaken && memRdLast_i;
      // writeback held until accepted
      if (xfer.wbStart) begin
        wbPending <= 1'b1;
      end else if (wbPending && memWrReady_i) begin
        wbPending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer.fillStart) begin
      rdAddrQ <= xfer.fillAddr;
    end
    if (beatTaken) begin
      fillBuf[beat*dcachePkg::WordW +: dcachePkg::WordW] <= memRdData_i;
    end
    if (xfer.wbStart) begin
      wrAddrQ <= xfer.wbAddr;
      wrLineQ <= xfer.wbLine;
    end
  end

  assign memRdValid_o  = rdPending;
  assign memRdAddr_o   = rdAddrQ;
  assign xfer.fillLine = fillBuf;
  assign xfer.fillDone = fillDoneQ;
  assign memWrValid_o  = wbPending;
  assign memWrAddr_o   = wrAddrQ;
  assign memWrData_o   = wrLineQ;
  assign xfer.wbDone   = wbPending && memWrReady_i;

endmodule

// ==== hdl/dcacheCtrl.sv ====
module dcacheCtrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            reqValid_i,
  input  logic            reqWrite_i,
  input  dcachePkg::addrT reqAddr_i,
  input  dcachePkg::wordT reqWdata_i,
  input  dcachePkg::strbT reqStrb_i,
  output logic            reqReady_o,
  output logic            respValid_o,
  output dcachePkg::wordT respRdata_o,
  arrayIf.ctrl            arr,
  lineIf.ctrl             xfer
);

  dcachePkg::cacheStateE      state;
  dcachePkg::cacheStateE      stateNext;
  logic                       installed;
  logic                       reqWriteQ;
  dcachePkg::addrT            reqAddrQ;
  dcachePkg::wordT            reqWdataQ;
  dcachePkg::strbT            reqStrbQ;
  dcachePkg::tagT             tagQ;
  dcachePkg::indexT           indexQ;
  dcachePkg::beatT            wordSel;
  logic [dcachePkg::Ways-1:0] wayHit;
  logic                       hit;
  dcachePkg::lineT            hitLine;
  dcachePkg::wordT            laneMask;
  dcachePkg::lineT            storeMask;
  dcachePkg::lineT            storeData;

  assign tagQ    = reqAddrQ[dcachePkg::AddrW-1 -: dcachePkg::TagW];
  assign indexQ  = reqAddrQ[dcachePkg::OffsetW +: dcachePkg::IndexW];
  assign wordSel = reqAddrQ[dcachePkg::OffsetW-1 -: $bits(dcachePkg::beatT)];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= dcachePkg::idle;
      installed <= 1'b0;
    end else begin
      state <= stateNext;
      // remembers that the store bytes already went in with the fill
      if (state == dcachePkg::install) begin
        installed <= 1'b1;
      end else if (state == dcachePkg::idle) begin
        installed <= 1'b0;
      end
    end
  end

  // accepted request
  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqWriteQ <= reqWrite_i;
      reqAddrQ  <= reqAddr_i;
      reqWdataQ <= reqWdata_i;
      reqStrbQ  <= reqStrb_i;
    end
  end

  // tag compare on both ways
  always_comb begin
    for (int w = 0; w < dcachePkg::Ways; w++) begin
      wayHit[w] = arr.rdValid[w] && (arr.rdTag[w] == tagQ);
    end
  end
  assign hit     = |wayHit;
  assign hitLine = arr.rdLine[wayHit[1]];

  always_comb begin
    stateNext      = state;
    xfer.fillStart = 1'b0;
    xfer.wbStart   = 1'b0;
    case (state)
      dcachePkg::idle: begin
        if (reqValid_i) begin
          stateNext = dcachePkg::compare;
        end
      end
      dcachePkg::compare: begin
        if (hit) begin
          stateNext = dcachePkg::idle;
        end else if (arr.victimDirty) begin
          xfer.wbStart = 1'b1;
          stateNext    = dcachePkg::writeBack;
        end else begin
          xfer.fillStart = 1'b1;
          stateNext      = dcachePkg::refill;
        end
      end
      dcachePkg::writeBack: begin
        if (xfer.wbDone) begin
          xfer.fillStart = 1'b1;
          stateNext      = dcachePkg::refill;
        end
      end
      dcachePkg::refill: begin
        if (xfer.fillDone) begin
          stateNext = dcachePkg::install;
        end
      end
      dcachePkg::install: stateNext = dcachePkg::compare;
      default: stateNext = dcachePkg::idle;
    endcase
  end

  assign reqReady_o  = (state == dcachePkg::idle);
  assign respValid_o = (state == dcachePkg::compare) && hit;
  assign respRdata_o = (respValid_o && !reqWriteQ) ?
                       hitLine[wordSel*dcachePkg::WordW +: dcachePkg::WordW] : '0;

  // byte strobes widened to bit lanes, then moved to the word slot
  always_comb begin
    for (int b = 0; b < dcachePkg::WordW/8; b++) begin
      laneMask[b*8 +: 8] = {8{reqStrbQ[b]}};
    end
  end
  assign storeMask = reqWriteQ ?
                     (dcachePkg::lineT'(laneMask) << (wordSel*dcachePkg::WordW)) : '0;
  assign storeData = dcachePkg::lineT'(reqWdataQ) << (wordSel*dcachePkg::WordW);

  // lookup uses the incoming address only while idle
  assign arr.rdIndex    = (state == dcachePkg::idle) ?
                          reqAddr_i[dcachePkg::OffsetW +: dcachePkg::IndexW] : indexQ;
  assign arr.installWr  = (state == dcachePkg::install);
  assign arr.storeWr    = (state == dcachePkg::compare) && hit && reqWriteQ && !installed;
  assign arr.hitWay     = wayHit[1];
  assign arr.installTag = tagQ;
  assign arr.storeData  = storeData;
  assign arr.storeMask  = storeMask;
  // store miss merges into the fetched line
  assign arr.refillLine = (xfer.fillLine & ~storeMask) | (storeData & storeMask);

  assign xfer.fillAddr = {tagQ, indexQ, {dcachePkg::OffsetW{1'b0}}};
  assign xfer.wbAddr   = {arr.rdTag[arr.victimWay], indexQ, {dcachePkg::OffsetW{1'b0}}};
  assign xfer.wbLine   = arr.rdLine[arr.victimWay];

endmodule

// ==== hdl/dcacheTop.sv ====
module dcacheTop (
  input  logic            clk,
  input  logic            rst_n,
  // cpu load/store port
  input  logic            reqValid_i,
  output logic            reqReady_o,
  input  logic            reqWrite_i,
  input  dcachePkg::addrT reqAddr_i,
  input  dcachePkg::wordT reqWdata_i,
  input  dcachePkg::strbT reqStrb_i,
  output logic            respValid_o,
  output dcachePkg::wordT respRdata_o,
  // memory line read
  output logic            memRdValid_o,
  input  logic            memRdReady_i,
  output dcachePkg::addrT memRdAddr_o,
  input  dcachePkg::wordT memRdData_i,
  input  logic            memRdDataValid_i,
  input  logic            memRdLast_i,
  // memory line write
  output logic            memWrValid_o,
  input  logic            memWrReady_i,
  output dcachePkg::addrT memWrAddr_o,
  output dcachePkg::lineT memWrData_o
);

  arrayIf arrayBus ();
  lineIf  lineBus ();

  dcacheCtrl ctrlInst (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqWrite_i  (reqWrite_i),
    .reqAddr_i   (reqAddr_i),
    .reqWdata_i  (reqWdata_i),
    .reqStrb_i   (reqStrb_i),
    .reqReady_o  (reqReady_o),
    .respValid_o (respValid_o),
    .respRdata_o (respRdata_o),
    .arr         (arrayBus.ctrl),
    .xfer        (lineBus.ctrl)
  );

  cacheArrays arraysInst (
    .clk   (clk),
    .rst_n (rst_n),
    .arr   (arrayBus.store)
  );

  lineTransfer transferInst (
    .clk              (clk),
    .rst_n            (rst_n),
    .xfer             (lineBus.mem),
    .memRdValid_o     (memRdValid_o),
    .memRdReady_i     (memRdReady_i),
    .memRdAddr_o      (memRdAddr_o),
    .memRdData_i      (memRdData_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrReady_i     (memWrReady_i),
    .memWrAddr_o      (memWrAddr_o),
    .memWrData_o      (memWrData_o)
  );

endmodule

// ==== tests/dcacheTb.sv ====
module dcacheTb;

  localparam int ReadyTimeout = 50;
  localparam int RespTimeout  = 200;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            reqValid_i;
  logic            reqReady_o;
  logic            reqWrite_i;
  dcachePkg::addrT reqAddr_i;
  dcachePkg::wordT reqWdata_i;
  dcachePkg::strbT reqStrb_i;
  logic            respValid_o;
  dcachePkg::wordT respRdata_o;
  logic            memRdValid_o;
  logic            memRdReady_i;
  dcachePkg::addrT memRdAddr_o;
  dcachePkg::wordT memRdData_i;
  logic            memRdDataValid_i;
  logic            memRdLast_i;
  logic            memWrValid_o;
  logic            memWrReady_i;
  dcachePkg::addrT memWrAddr_o;
  dcachePkg::lineT memWrData_o;

  // memory contents and the CPU-visible reference, both word addressed
  dcachePkg::wordT memWords [dcachePkg::addrT];
  dcachePkg::wordT refWords [dcachePkg::addrT];
  int              errors;
  string           currentName;

  always #5 clk = ~clk;

  dcacheTop dcacheTop_inst (.*);

  // untouched words read back as their own address with a fixed xor
  function automatic dcachePkg::wordT fillPattern(input dcachePkg::addrT a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic dcachePkg::wordT refWord(input dcachePkg::addrT a);
    return refWords.exists(a) ? refWords[a] : fillPattern(a);
  endfunction

  function automatic dcachePkg::wordT memWord(input dcachePkg::addrT a);
    return memWords.exists(a) ? memWords[a] : fillPattern(a);
  endfunction

  task automatic applyStore(input dcachePkg::addrT a, input dcachePkg::wordT d,
                            input dcachePkg::strbT s);
    dcachePkg::addrT wordAddr;
    dcachePkg::wordT w;
    int              b;
    wordAddr = {a[dcachePkg::AddrW-1:2], 2'b00};
    w = refWord(wordAddr);
    for (b = 0; b < dcachePkg::WordW/8; b++) begin
      if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    refWords[wordAddr] = w;
  endtask

  // called in the cycle whose closing edge completes the write handshake
  task automatic checkWriteback();
    dcachePkg::addrT a;
    dcachePkg::wordT actual;
    int              w;
    assert (memWrAddr_o[dcachePkg::OffsetW-1:0] == '0) else begin
      $display("Error: writeback address %h in %0s is not line aligned",
               memWrAddr_o, currentName);
      errors++;
    end
    for (w = 0; w < dcachePkg::WordsPerLine; w++) begin
      a = memWrAddr_o + 4 * w;
      actual = memWrData_o[w*dcachePkg::WordW +: dcachePkg::WordW];
      assert (actual == refWord(a)) else begin
        $display("Error: test %0s writeback word %h expected %h actual %h",
                 currentName, a, refWord(a), actual);
        errors++;
      end
      memWords[a] = actual;
    end
  endtask

  task automatic serveRead();
    dcachePkg::addrT lineAddr;
    int              b;
    repeat ($urandom % 4) begin
      @(posedge clk);
      #1;
    end
    lineAddr = memRdAddr_o;
    assert (lineAddr[dcachePkg::OffsetW-1:0] == '0) else begin
      $display("Error: read address %h in %0s is not line aligned", lineAddr, currentName);
      errors++;
    end
    memRdReady_i = 1'b1;
    @(posedge clk);
    #1;
    memRdReady_i = 1'b0;
    // beats in ascending order, each after a short random gap
    for (b = 0; b < dcachePkg::WordsPerLine; b++) begin
      repeat ($urandom % 4) begin
        @(posedge clk);
        #1;
      end
      memRdDataValid_i = 1'b1;
      memRdData_i      = memWord(lineAddr + 4 * b);
      memRdLast_i      = (b == dcachePkg::WordsPerLine - 1);
      @(posedge clk);
      #1;
      memRdDataValid_i = 1'b0;
      memRdLast_i      = 1'b0;
    end
  endtask

  // memory read side
  initial begin
    memRdReady_i     = 1'b0;
    memRdData_i      = '0;
    memRdDataValid_i = 1'b0;
    memRdLast_i      = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (memRdValid_o) serveRead();
    end
  end

  // memory write side, ready drops at random
  initial begin
    memWrReady_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      memWrReady_i = ($urandom % 3) == 0;
      if (memWrValid_o && memWrReady_i) checkWriteback();
    end
  end

  task automatic runRequest(input logic wr, input dcachePkg::addrT a,
                            input dcachePkg::wordT d, input dcachePkg::strbT s,
                            output dcachePkg::wordT rdata, output int lat,
                            output logic timedOut);
    int waited;
    timedOut = 1'b0;
    rdata    = '0;
    lat      = 0;
    waited   = 0;
    while (!reqReady_o && waited < ReadyTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!reqReady_o) begin
      $display("cache did not raise reqReady_o within %0d cycles", ReadyTimeout);
      timedOut = 1'b1;
      return;
    end
    reqValid_i = 1'b1;
    reqWrite_i = wr;
    reqAddr_i  = a;
    reqWdata_i = d;
    reqStrb_i  = s;
    @(posedge clk);
    #1;
    reqValid_i = 1'b0;
    lat        = 1;
    while (!respValid_o && lat < RespTimeout) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!respValid_o) begin
      $display("no response from the cache within %0d cycles", RespTimeout);
      timedOut = 1'b1;
      return;
    end
    rdata = respRdata_o;
  endtask

  initial begin : mainFlow
    int              fd;
    int              fields;
    int              latency;
    int              errorsBefore;
    int              testsRun;
    int              testsFailed;
    logic            aborted;
    logic            timedOut;
    string           lineStr;
    logic [8*24-1:0] testName;
    logic [7:0]      opCode;
    dcachePkg::addrT addr;
    dcachePkg::wordT data;
    dcachePkg::strbT strb;
    dcachePkg::wordT expectVal;
    dcachePkg::wordT rdata;

    void'($urandom(32'h674c_c4ec));
    rst_n       = 1'b0;
    reqValid_i  = 1'b0;
    reqWrite_i  = 1'b0;
    reqAddr_i   = '0;
    reqWdata_i  = '0;
    reqStrb_i   = '0;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    aborted     = 1'b0;
    currentName = "reset";
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    assert (reqReady_o && !respValid_o && !memRdValid_o && !memWrValid_o) else begin
      $display("cache outputs are not idle after reset");
      errors++;
    end

    fd = $fopen("tests/dcache_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tests/dcache_trace.txt");
      errors++;
      aborted = 1'b1;
    end
    while (!aborted && $fgets(lineStr, fd) != 0) begin
      if (lineStr.len() < 2 || lineStr[0] == "#") continue;
      fields = $sscanf(lineStr, "%s %s %h %h %h %h",
                       testName, opCode, addr, data, strb, expectVal);
      if (fields != 6) continue;
      currentName  = string'(testName);
      errorsBefore = errors;
      runRequest(opCode == "S", addr, data, strb, rdata, latency, timedOut);
      if (timedOut) begin
        errors++;
        aborted = 1'b1;
      end else begin
        assert (rdata == expectVal) else begin
          $display("Error: test %0s expected %h actual %h", currentName, expectVal, rdata);
          errors++;
        end
        // a hit answers in the cycle right after acceptance
        if (opCode == "H") begin
          assert (latency == 1) else begin
            $display("Error: test %0s expected latency 1 actual %0d", currentName, latency);
            errors++;
          end
        end
        if (opCode == "S") applyStore(addr, data, strb);
        @(posedge clk);
        #1;
        assert (!respValid_o) else begin
          $display("respValid_o stayed high for a second cycle in %0s", currentName);
          errors++;
        end
      end
      testsRun++;
      if (errors == errorsBefore) begin
        $display("%0s ok", currentName);
      end else begin
        testsFailed++;
        $display("%0s FAILED", currentName);
      end
    end
    if (fd != 0) $fclose(fd);
    assert (testsRun > 0) else begin
      $display("no tests were read from the trace");
      errors++;
    end
    $display("tests run: %0d, failing tests: %0d, errors: %0d", testsRun, testsFailed, errors);
    if (errors == 0 && !aborted) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tests/dcache_trace.txt ====
# columns: name, op (L load, S store, H load that must hit), address, data, strobe, response
# all values hex; a store answers with zero

# cold miss, then hit latency on the same line
coldLoad       L 00000100 00000000 0 5a5a0100
hitLoad        H 00000104 00000000 0 5a5a0104

# store hit, low half merged
storeHit       S 00000108 deadbeef 3 00000000
loadAfterHit   H 00000108 00000000 0 5a5abeef

# store miss allocates and merges the high half
storeMiss      S 00000234 11223344 c 00000000
loadAfterMiss  H 00000234 00000000 0 11220234

# three lines in set 4 force dirty evictions
evictStA       S 00001040 aaaaaaaa f 00000000
evictStB       S 00002044 bbbbbbbb 1 00000000
evictLdC       L 00003048 00000000 0 5a5a3048
reloadA        L 00001040 00000000 0 aaaaaaaa
reloadB        L 00002044 00000000 0 5a5a20bb
reloadAHit     H 0000104c 00000000 0 5a5a104c

# second round with a middle byte store
storeHitB      S 00002048 99887766 6 00000000
loadB2         H 00002048 00000000 0 5a887748
loadB1         H 00002044 00000000 0 5a5a20bb
reloadC        L 0000304c 00000000 0 5a5a304c
reloadA2       L 00001040 00000000 0 aaaaaaaa
reloadB2       L 00002048 00000000 0 5a887748

// ==== dcacheTop.f ====
hdl/dcachePkg.sv
hdl/cacheIfs.sv
hdl/cacheArrays.sv
hdl/lineTransfer.sv
hdl/dcacheCtrl.sv
hdl/dcacheTop.sv
tests/dcacheTb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcacheTb
FILELIST  ?= dcacheTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
